/* source/obj_pkg.sv */
// shared widths, scanner states and screen constants for the object line engine; import with obj_pkg::*
package obj_pkg;

    // object table
    typedef logic [9:0]  table_addr_t;  // entry index, 1024 entries
    typedef logic [15:0] table_word_t;  // x, y, code or attr

    // screen geometry
    typedef logic [8:0]  hpos_t;        // pixel column, also the render line
    typedef logic [3:0]  tile_sub_t;    // n, m or vsub inside a tile

    // pixel fields
    typedef logic [2:0]  prio_t;        // x[15:13]
    typedef logic [11:0] pxl_t;         // {prio, palette, colour}

    // table walker states
    typedef enum logic [2:0] {
        idle,       // waiting for a start edge
        fetch,      // table read in flight, then end marker check
        match,      // matcher result ready
        wait_idle,  // hold until the drawer is free
        issue,      // draw strobe is out
        advance     // step to the next entry
    } scan_st_t;

    // visible width, columns at or past this are dropped
    localparam hpos_t screen_w = 9'd384;

endpackage

/* source/obj_table.sv */
// object table RAM: software writes whole entries, the scanner reads one entry per cycle
module obj_table import obj_pkg::*; #(
    parameter int table_depth_log2 = 10
) (
    input  logic                        clk,
    // software side
    input  logic                        tbl_we,
    input  logic [table_depth_log2-1:0] tbl_waddr,
    input  logic [63:0]                 tbl_wdata,   // {attr, code, y, x}
    // scanner side
    input  logic [table_depth_log2-1:0] table_addr,
    output table_word_t                 tbl_x,
    output table_word_t                 tbl_y,
    output table_word_t                 tbl_code,
    output table_word_t                 tbl_attr
);

    logic [63:0] mem [2**table_depth_log2];
    logic [63:0] rd_q;  // registered entry, valid one cycle after table_addr

    // write port, full entry at a time
    always_ff @(posedge clk) begin
        if (tbl_we) begin
            mem[tbl_waddr] <= tbl_wdata;
        end
    end

    // scanner read port, independent of the writes
    always_ff @(posedge clk) begin
        rd_q <= mem[table_addr];
    end

    // split into the four words
    assign tbl_x    = rd_q[15:0];
    assign tbl_y    = rd_q[31:16];
    assign tbl_code = rd_q[47:32];
    assign tbl_attr = rd_q[63:48];

endmodule

/* source/obj_tile_match.sv */
// line coverage test for one table entry; results come out one cycle after the inputs
module obj_tile_match import obj_pkg::*; (
    input  logic        clk,
    // current table entry
    input  table_word_t tbl_code,
    input  table_word_t tbl_y,
    input  table_word_t tbl_attr,
    // from the scanner
    input  tile_sub_t   n,          // horizontal tile index
    input  hpos_t       vrenderf,   // render line, flip applied
    // results
    output logic        inzone,
    output tile_sub_t   vsub,
    output table_word_t code_mn
);

    hpos_t     row;     // line offset inside the object, mod 512
    hpos_t     span;    // object height in lines
    tile_sub_t tile_m;
    tile_sub_t m;       // tile row after vflip
    logic      vflip;

    assign tile_m = tbl_attr[15:12];
    assign vflip  = tbl_attr[6];

    // wraps at 512, so objects across the bottom edge still match
    assign row  = vrenderf - tbl_y[8:0];
    assign span = {1'b0, tile_m, 4'd0} + 9'd16;   // 16 * (tile_m + 1), up to 256

    // row[8] is clear whenever the object covers the line
    assign m = vflip ? tile_m - row[7:4] : row[7:4];

    always_ff @(posedge clk) begin
        inzone  <= row < span;
        vsub    <= row[3:0] ^ {4{vflip}};  // mirrored line inside the tile
        // code steps by 1 per column and 16 per row
        code_mn <= tbl_code + {12'd0, n} + {8'd0, m, 4'd0};
    end

endmodule

/* source/obj_scan.sv */
// per-line table walker: finds objects on the render line, expands them into tiles, feeds the drawer
module obj_scan import obj_pkg::*; #(
    parameter int table_depth_log2 = 10
) (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        start,       // level, edge detected here
    input  logic                        flip,
    input  hpos_t                       vrender,
    // table read port
    output logic [table_depth_log2-1:0] table_addr,
    input  table_word_t                 tbl_x,
    input  table_word_t                 tbl_y,
    input  table_word_t                 tbl_code,
    input  table_word_t                 tbl_attr,
    // matcher
    input  logic                        inzone,
    input  tile_sub_t                   vsub,
    input  table_word_t                 code_mn,
    output tile_sub_t                   n,
    output hpos_t                       vrenderf,
    // drawer request
    output logic                        dr_start,
    output table_word_t                 dr_code,
    output table_word_t                 dr_attr,     // {0, vsub, attr[7:0]}
    output hpos_t                       dr_hpos,
    output prio_t                       dr_prio,
    input  logic                        dr_idle,
    output logic                        scan_busy
);

    scan_st_t  st;
    logic      start_q;
    logic      start_edge;
    logic      fwait;       // first fetch cycle, table data not back yet
    logic      end_mark;
    logic      hflip;
    tile_sub_t tile_n;
    tile_sub_t npos;        // screen column of tile n

    assign start_edge = start & ~start_q;
    assign tile_n     = tbl_attr[11:8];
    assign hflip      = tbl_attr[5];

    // y bit 15 or attr[15:8] all ones ends the list
    assign end_mark = tbl_y[15] | (&tbl_attr[15:8]);

    assign scan_busy = (st != idle) | start_edge;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st         <= idle;
            start_q    <= 1'b0;
            fwait      <= 1'b0;
            table_addr <= '0;
            n          <= '0;
            dr_start   <= 1'b0;
        end else begin
            start_q  <= start;
            dr_start <= 1'b0;   // one cycle strobe
            case (st)
                idle: begin
                    table_addr <= '0;
                end
                fetch: begin
                    fwait <= 1'b0;
                    if (!fwait) begin
                        // words valid now, matcher registers them this cycle
                        st <= end_mark ? idle : match;
                    end
                end
                match: begin
                    st <= inzone ? wait_idle : advance;
                end
                wait_idle: begin
                    if (dr_idle) begin  // back-pressure from the drawer
                        dr_start <= 1'b1;
                        st       <= issue;
                    end
                end
                issue: begin
                    if (n == tile_n) begin
                        st <= advance;
                    end else begin
                        n  <= n + 1'b1;
                        st <= match;    // one cycle for code_mn to follow n
                    end
                end
                advance: begin
                    n     <= '0;
                    fwait <= 1'b1;
                    if (&table_addr) begin
                        st <= idle;     // whole table walked
                    end else begin
                        table_addr <= table_addr + 1'b1;
                        st         <= fetch;
                    end
                end
                default: st <= idle;
            endcase
            // new line wins over anything in flight
            if (start_edge) begin
                st         <= fetch;
                fwait      <= 1'b1;
                table_addr <= '0;
                n          <= '0;
                dr_start   <= 1'b0;
            end
        end
    end

    // job fields and line latch
    always_ff @(posedge clk) begin
        if (start_edge) begin
            vrenderf <= vrender ^ {1'b0, {8{flip}}};  // flip mirrors the low 8 bits
        end
        if (st == fetch && !fwait) begin
            npos <= hflip ? tile_n : 4'd0;   // right to left when mirrored
        end
        if (st == issue) begin
            npos <= hflip ? npos - 1'b1 : npos + 1'b1;
        end
        if (st == wait_idle && dr_idle) begin
            dr_code <= code_mn;
            dr_attr <= {4'd0, vsub, tbl_attr[7:0]};
            dr_hpos <= tbl_x[8:0] + {1'b0, npos, 4'd0};
            dr_prio <= tbl_x[15:13];
        end
    end

endmodule

/* source/obj_tile_rom.sv */
// stand-in graphics ROM: synchronous read of one 16-pixel tile row from an arithmetic pattern
module obj_tile_rom (
    input  logic        clk,
    input  logic [19:0] rom_addr,   // {code, vsub}
    output logic [63:0] rom_data    // pixel k in bits 4k+3:4k
);

    logic [3:0] code_lo;
    logic [3:0] vsub;

    // only the low code nibble matters for the pattern
    assign code_lo = rom_addr[7:4];
    assign vsub    = rom_addr[3:0];

    // pixel k = code[3:0] + vsub + k, mod 16
    always_ff @(posedge clk) begin
        for (int k = 0; k < 16; k++) begin
            rom_data[4*k +: 4] <= code_lo + vsub + 4'(k);   // 0 is transparent
        end
    end

endmodule

/* source/obj_draw.sv */
// tile drawer: one 16-pixel row per job, fetched from the ROM and written into the line buffer
module obj_draw import obj_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    // job from the scanner
    input  logic        dr_start,
    input  table_word_t dr_code,
    input  table_word_t dr_attr,    // vsub in 11:8, hflip bit 5, palette 4:0
    input  hpos_t       dr_hpos,
    input  prio_t       dr_prio,
    output logic        dr_idle,
    // graphics ROM
    output logic [19:0] rom_addr,
    input  logic [63:0] rom_data,
    // line buffer write
    output logic        buf_we,
    output hpos_t       buf_addr,
    output pxl_t        buf_pxl
);

    logic        fetch_q;   // ROM address out
    logic        load_q;    // ROM data back
    logic        drawing;
    tile_sub_t   col;
    table_word_t job_code;
    tile_sub_t   job_vsub;
    logic        job_hflip;
    logic [4:0]  job_pal;
    hpos_t       job_hpos;
    prio_t       job_prio;
    logic [63:0] rev;       // ROM row with pixel order reversed
    logic [63:0] row_q;     // current pixel always in the low nibble

    assign rom_addr = {job_code, job_vsub};

    always_comb begin
        for (int k = 0; k < 16; k++) begin
            rev[4*k +: 4] = rom_data[4*(15-k) +: 4];
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dr_idle <= 1'b1;
            fetch_q <= 1'b0;
            load_q  <= 1'b0;
            drawing <= 1'b0;
            col     <= '0;
        end else begin
            fetch_q <= dr_start & dr_idle;
            load_q  <= fetch_q;
            if (dr_start && dr_idle) begin
                dr_idle <= 1'b0;
            end
            if (load_q) begin
                drawing <= 1'b1;
                col     <= '0;
            end
            if (drawing) begin
                col <= col + 1'b1;
                if (col == 4'd15) begin     // last column written this cycle
                    drawing <= 1'b0;
                    dr_idle <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dr_start && dr_idle) begin
            job_code  <= dr_code;
            job_vsub  <= dr_attr[11:8];
            job_hflip <= dr_attr[5];
            job_pal   <= dr_attr[4:0];
            job_hpos  <= dr_hpos;
            job_prio  <= dr_prio;
        end
        if (load_q) begin
            row_q <= job_hflip ? rev : rom_data;
        end else if (drawing) begin
            row_q <= row_q >> 4;
        end
    end

    // column wraps at 512, off-screen and transparent pixels are skipped
    assign buf_addr = job_hpos + {5'd0, col};
    assign buf_we   = drawing && (row_q[3:0] != 4'd0) && (buf_addr < screen_w);
    assign buf_pxl  = {job_prio, job_pal, row_q[3:0]};

endmodule

/* source/obj_line_buf.sv */
// object line buffer: first write to a pixel sticks, video readout returns and erases each entry
module obj_line_buf import obj_pkg::*; #(
    parameter int line_w_log2 = 9
) (
    input  logic                   clk,
    input  logic                   rst,
    // drawer side
    input  logic                   buf_we,
    input  logic [line_w_log2-1:0] buf_addr,
    input  pxl_t                   buf_pxl,
    // video side
    input  logic                   rd_en,
    input  logic [line_w_log2-1:0] rd_addr,
    output pxl_t                   rd_pxl,
    output logic                   rd_opaque
);

    pxl_t                      mem [2**line_w_log2];
    logic [2**line_w_log2-1:0] opaque;  // set once a pixel has been written

    // pixel data, only stored if nobody got there first
    always_ff @(posedge clk) begin
        if (buf_we && !opaque[buf_addr]) begin
            mem[buf_addr] <= buf_pxl;
        end
        if (rd_en) begin
            rd_pxl <= opaque[rd_addr] ? mem[rd_addr] : '0;   // cleared entries read as zero
        end
    end

    // flags: set by the drawer, cleared by the readout
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            opaque    <= '0;
            rd_opaque <= 1'b0;
        end else begin
            if (buf_we) begin
                opaque[buf_addr] <= 1'b1;
            end
            if (rd_en) begin
                rd_opaque       <= opaque[rd_addr];
                opaque[rd_addr] <= 1'b0;    // erase wins on a same-cycle clash
            end
        end
    end

endmodule

/* source/obj_line.sv */
// object line engine top: table, scanner, matcher, drawer, tile ROM and line buffer wired together
module obj_line import obj_pkg::*; #(
    parameter int table_depth_log2 = 10,
    parameter int line_w_log2      = 9
) (
    input  logic                        clk,
    input  logic                        rst,
    // table write port
    input  logic                        tbl_we,
    input  logic [table_depth_log2-1:0] tbl_waddr,
    input  logic [63:0]                 tbl_wdata,
    // scanline control
    input  logic                        start,
    input  hpos_t                       vrender,
    input  logic                        flip,
    output logic                        busy,
    // video readout
    input  logic                        rd_en,
    input  logic [line_w_log2-1:0]      rd_addr,
    output pxl_t                        rd_pxl,
    output logic                        rd_opaque
);

    logic [table_depth_log2-1:0] table_addr;
    table_word_t tbl_x, tbl_y, tbl_code, tbl_attr;
    logic        inzone;
    tile_sub_t   vsub;
    tile_sub_t   n;
    table_word_t code_mn;
    hpos_t       vrenderf;
    logic        dr_start;
    logic        dr_idle;
    table_word_t dr_code;
    table_word_t dr_attr;
    hpos_t       dr_hpos;
    prio_t       dr_prio;
    logic        scan_busy;
    logic [19:0] rom_addr;
    logic [63:0] rom_data;
    logic        buf_we;
    hpos_t       buf_addr;
    pxl_t        buf_pxl;

    // line is done once the walk ended and the last tile is written
    assign busy = scan_busy | ~dr_idle;

    obj_table #(.table_depth_log2(table_depth_log2)) obj_table_inst (
        .clk, .tbl_we, .tbl_waddr, .tbl_wdata,
        .table_addr, .tbl_x, .tbl_y, .tbl_code, .tbl_attr
    );

    obj_tile_match obj_tile_match_inst (
        .clk, .tbl_code, .tbl_y, .tbl_attr,
        .n, .vrenderf, .inzone, .vsub, .code_mn
    );

    obj_scan #(.table_depth_log2(table_depth_log2)) obj_scan_inst (
        .clk, .rst, .start, .flip, .vrender,
        .table_addr, .tbl_x, .tbl_y, .tbl_code, .tbl_attr,
        .inzone, .vsub, .code_mn, .n, .vrenderf,
        .dr_start, .dr_code, .dr_attr, .dr_hpos, .dr_prio, .dr_idle,
        .scan_busy
    );

    obj_draw obj_draw_inst (
        .clk, .rst, .dr_start, .dr_code, .dr_attr, .dr_hpos, .dr_prio, .dr_idle,
        .rom_addr, .rom_data, .buf_we, .buf_addr, .buf_pxl
    );

    obj_tile_rom obj_tile_rom_inst (
        .clk, .rom_addr, .rom_data
    );

    obj_line_buf #(.line_w_log2(line_w_log2)) obj_line_buf_inst (
        .clk, .rst, .buf_we, .buf_addr, .buf_pxl,
        .rd_en, .rd_addr, .rd_pxl, .rd_opaque
    );

endmodule

/* tests/obj_line_chk.sv */
// scanner handshake and reset assertions bound into obj_scan
module obj_line_chk #(
    parameter int table_depth_log2 = 10
) (
    input logic                        clk,
    input logic                        rst,
    input logic                        dr_start,
    input logic                        dr_idle,
    input logic [table_depth_log2-1:0] table_addr,
    input logic                        scan_busy
);
    timeunit 1ns;
    timeprecision 1ps;

    // request only to a free drawer
    assert property (@(posedge clk) disable iff (rst) dr_start |-> dr_idle)
        else $error("dr_start raised while drawer busy");

    // one-cycle strobe that the drawer answers by dropping idle
    assert property (@(posedge clk) disable iff (rst) dr_start |=> !dr_start && !dr_idle)
        else $error("dr_start longer than one cycle or job not taken");

    // walk moves one entry at a time or restarts at entry 0
    assert property (@(posedge clk) disable iff (rst)
        table_addr != $past(table_addr) |->
            table_addr == '0 || table_addr == $past(table_addr) + 1'b1)
        else $error("table_addr jumped out of the entry sequence");

    // quiet straight out of reset
    assert property (@(posedge clk) rst |=> !scan_busy && dr_idle && !dr_start)
        else $error("busy high after reset");

endmodule

bind obj_scan obj_line_chk #(.table_depth_log2(table_depth_log2)) obj_line_chk_inst (
    .clk, .rst, .dr_start, .dr_idle, .table_addr, .scan_busy
);

/* tests/obj_line_tb.sv */
// drives random object tables through the line engine and checks every rendered line and its erase
module obj_line_tb import obj_pkg::*; ;
    timeunit 1ns;
    timeprecision 1ps;

    logic        clk, rst, tbl_we, start, flip, busy, rd_en, rd_opaque;
    table_addr_t tbl_waddr;
    logic [63:0] tbl_wdata;
    hpos_t       vrender, rd_addr;
    pxl_t        rd_pxl;

    table_word_t tx [1024];     // software copy of the table
    table_word_t ty [1024];
    table_word_t tc [1024];
    table_word_t ta [1024];
    pxl_t        exp_pxl [512]; // expected line
    bit          exp_op  [512];
    integer      seed;

    obj_line #(.table_depth_log2(10), .line_w_log2(9)) obj_line_inst (
        .clk, .rst, .tbl_we, .tbl_waddr, .tbl_wdata, .start, .vrender, .flip, .busy,
        .rd_en, .rd_addr, .rd_pxl, .rd_opaque
    );

    always #2 clk = ~clk;   // 4 ns period

    // expected line straight from the coverage, tile and ROM rules
    function void paint_line(input hpos_t vr, input bit flp);
        hpos_t       vrf, row, hp, c;
        table_word_t cd;
        tile_sub_t   tm, tn, m, vs, np;
        logic [3:0]  v;
        bit          vfl, hfl;
        for (int i = 0; i < 512; i++) begin
            exp_op[i]  = 0;
            exp_pxl[i] = '0;
        end
        vrf = flp ? {vr[8], ~vr[7:0]} : vr;
        for (int e = 0; e < 1024; e++) begin
            if (ty[e][15] || ta[e][15:8] == 8'hff) break;  // end of list
            tm  = ta[e][15:12];
            tn  = ta[e][11:8];
            vfl = ta[e][6];
            hfl = ta[e][5];
            row = vrf - ty[e][8:0];
            if (int'(row) < 16 * (int'(tm) + 1)) begin
                m  = vfl ? 4'(int'(tm) - int'(row) / 16) : 4'(int'(row) / 16);
                vs = vfl ? 4'(15 - int'(row) % 16) : 4'(int'(row) % 16);
                for (int nn = 0; nn <= int'(tn); nn++) begin
                    np = hfl ? 4'(int'(tn) - nn) : 4'(nn);
                    cd = 16'(int'(tc[e]) + nn + 16 * int'(m));
                    hp = 9'(int'(tx[e][8:0]) + 16 * int'(np));
                    for (int k = 0; k < 16; k++) begin
                        c = 9'(int'(hp) + k);
                        v = 4'(int'(cd[3:0]) + int'(vs) + (hfl ? 15 - k : k));
                        if (v != 0 && c < screen_w && !exp_op[c]) begin  // first writer keeps it
                            exp_op[c]  = 1;
                            exp_pxl[c] = {tx[e][15:13], ta[e][4:0], v};
                        end
                    end
                end
            end
        end
    endfunction

    task automatic check_pxl(input string name, input pxl_t got, input pxl_t exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got %h expected %h", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1, "pixel mismatch");
        end
    endtask

    task automatic check_opaque(input string name, input bit got, input bit exp);
        if (got !== exp) begin
            $display("** Error at %0t ns: %s got %0b expected %0b", $time, name, got, exp);
            $display("Test failures found");
            $fatal(1, "opaque flag mismatch");
        end
    endtask

    // random object covering line vr with x from xbase up to xbase+xspan-1
    task automatic make_obj(input int e, input hpos_t vr, input bit flips,
                            input int xbase, input int xspan);
        logic [31:0] r, r2;
        tile_sub_t   tm;
        hpos_t       row;
        r   = $random(seed);
        r2  = $random(seed);
        tm  = {2'b00, r[1:0]};      // keeps attr[15:8] off the end marker
        row = 9'(int'(r[15:8]) % (16 * (int'(tm) + 1)));
        ty[e] = {7'd0, 9'(vr - row)};
        tx[e] = {r[18:16], 4'd0, 9'(xbase + int'(r[31:24]) % xspan)};
        tc[e] = r2[15:0];
        ta[e] = {tm, 2'b00, r[3:2], r2[23:16] & (flips ? 8'hff : 8'h9f)};
    endtask

    task automatic mark_end(input int e);
        ty[e] = 16'h8000;
        ta[e] = '0;
    endtask

    task automatic load_table();
        for (int e = 0; e < 1024; e++) begin
            @(posedge clk);
            tbl_we    <= 1'b1;
            tbl_waddr <= table_addr_t'(e);
            tbl_wdata <= {ta[e], tc[e], ty[e], tx[e]};
        end
        @(posedge clk);
        tbl_we <= 1'b0;
    endtask

    // reads all positions against the expected line or against an empty one
    task automatic read_pass(input bit want_data);
        for (int a = 0; a < 512; a++) begin
            @(posedge clk);
            rd_en   <= 1'b1;
            rd_addr <= hpos_t'(a);
            @(posedge clk);
            rd_en   <= 1'b0;
            @(negedge clk);         // data settled one cycle after rd_en
            check_opaque($sformatf("rd_opaque[%0d]", a), rd_opaque, want_data && exp_op[a]);
            check_pxl($sformatf("rd_pxl[%0d]", a), rd_pxl, want_data ? exp_pxl[a] : pxl_t'(0));
        end
    endtask

    task automatic run_line(input hpos_t vr, input bit flp, input int nobj);
        int cnt;
        int limit;
        cnt   = 0;
        limit = 1024 * 6 + 18 * nobj * 16 + 600;
        paint_line(vr, flp);
        @(posedge clk);
        vrender <= vr;
        flip    <= flp;
        start   <= 1'b1;
        @(posedge clk);
        start   <= 1'b0;
        do begin
            @(negedge clk);
            cnt++;
            if (cnt > limit) begin
                $display("timeout: busy still high after %0d cycles on line %0d", cnt, vr);
                $display("Test failures found");
                $fatal(1, "timeout");
            end
        end while (busy);
        read_pass(1'b1);
        read_pass(1'b0);    // buffer must be empty again
    endtask

    initial begin
        clk       = 0;
        rst       = 1;
        tbl_we    = 0;
        tbl_waddr = '0;
        tbl_wdata = '0;
        start     = 0;
        vrender   = '0;
        flip      = 0;
        rd_en     = 0;
        rd_addr   = '0;
        seed      = 32'h79e1_9c9d;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        // single tile without flips
        tx[0] = {3'd2, 4'd0, 9'd100};
        ty[0] = 16'd47;
        tc[0] = 16'h0025;
        ta[0] = 16'h0003;
        mark_end(1);
        load_table();
        run_line(9'd50, 0, 1);
        // multi tile over several lines
        for (int e = 0; e < 8; e++) make_obj(e, 9'd200, 0, 0, 400);
        mark_end(8);
        load_table();
        run_line(9'd200, 0, 8);
        run_line(9'd205, 0, 8);
        run_line(9'd217, 0, 8);
        run_line(9'd230, 0, 8);
        // mirrored objects under screen flip where line 120 maps to 135
        for (int e = 0; e < 10; e++) make_obj(e, 9'd135, 1, 0, 400);
        mark_end(10);
        load_table();
        run_line(9'd120, 1, 10);
        run_line(9'd128, 1, 10);
        run_line(9'd135, 0, 10);
        // overlaps in a narrow band
        for (int e = 0; e < 12; e++) make_obj(e, 9'd300, 1, 96, 64);
        mark_end(12);
        load_table();
        run_line(9'd300, 0, 12);
        run_line(9'd310, 0, 12);
        // y bit 15 marker followed by the attr marker
        for (int e = 0; e < 6; e++) make_obj(e, 9'd60, 1, 0, 400);
        ty[3][15] = 1'b1;
        load_table();
        run_line(9'd60, 0, 6);
        ty[3][15] = 1'b0;
        ta[4][15:8] = 8'hff;
        load_table();
        run_line(9'd60, 0, 6);
        // full table with the last entry on the line too
        for (int e = 0; e < 1024; e++) make_obj(e, (e % 16 == 0) ? 9'd60 : 9'(e * 7), 1, 0, 400);
        make_obj(1023, 9'd60, 1, 0, 400);
        load_table();
        run_line(9'd60, 0, 1024);
        // clipping at the right edge
        tx[0] = {3'd1, 4'd0, 9'd380};
        ty[0] = 16'd10;
        tc[0] = 16'h0001;
        ta[0] = 16'h0107;
        mark_end(1);
        load_table();
        run_line(9'd12, 0, 1);
        $display("All tests passed!");
        $finish;
    end

endmodule

/* files.f */
source/obj_pkg.sv
source/obj_table.sv
source/obj_tile_match.sv
source/obj_scan.sv
source/obj_tile_rom.sv
source/obj_draw.sv
source/obj_line_buf.sv
source/obj_line.sv
tests/obj_line_chk.sv
tests/obj_line_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -eo pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module obj_line_tb -f files.f -o obj_line_sim
./obj_dir/obj_line_sim | tee sim.log

if grep -q "Test failures found" sim.log; then
    echo "simulation FAILED"
    exit 1
fi
echo "simulation passed"
